/* src.f */
+incdir+verilog
+incdir+test
verilog/decode_pkg.sv
verilog/main_decoder.sv
verilog/decode_lane.sv
verilog/issue_dispatch.sv
verilog/retire_collector.sv
verilog/decode_cluster.sv
test/tb_decode_cluster.sv

/* test/decode_model.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// reserved encoding: only the invalid bit, which is the lsb of ctrl_t
localparam ctrl_t CTRL_RESERVED = ctrl_t'(14'h0001);

// reference decode, built from instruction classes
function automatic ctrl_t model_decode(input instr_t w);
    logic [5:0] op;
    logic [5:0] fn;
    logic [4:0] rs;
    logic [4:0] rt;
    logic       spec, alu_r, muldiv, mfhi, mflo, mthi, mtlo, jr, jalr;
    logic       quiet, imm, load, store, br, br_lnk, jmp, jal, mfc0, legal;
    ctrl_t      c;
    op     = w[31:26];
    rs     = w[25:21];
    rt     = w[20:16];
    fn     = w[5:0];
    spec   = (op == `EXE_NOP);
    alu_r  = spec && (fn inside {`EXE_ADD, `EXE_ADDU, `EXE_SUB, `EXE_SUBU, `EXE_AND, `EXE_OR,
                                 `EXE_XOR, `EXE_NOR, `EXE_SLT, `EXE_SLTU, `EXE_SLL, `EXE_SRL,
                                 `EXE_SRA, `EXE_SLLV, `EXE_SRLV, `EXE_SRAV});
    muldiv = spec && (fn inside {`EXE_MULT, `EXE_MULTU, `EXE_DIV, `EXE_DIVU});
    mfhi   = spec && (fn == `EXE_MFHI);
    mflo   = spec && (fn == `EXE_MFLO);
    mthi   = spec && (fn == `EXE_MTHI);
    mtlo   = spec && (fn == `EXE_MTLO);
    jr     = spec && (fn == `EXE_JR);
    jalr   = spec && (fn == `EXE_JALR);
    quiet  = (spec && (fn inside {`EXE_SYSCALL, `EXE_BREAK})) ||   // legal, no control set
             (op == `EXE_COP0_INST && (rs inside {`EXE_MTC0, `EXE_ERET}));
    imm    = op inside {`EXE_ADDI, `EXE_ADDIU, `EXE_SLTI, `EXE_SLTIU,
                        `EXE_ANDI, `EXE_ORI, `EXE_XORI, `EXE_LUI};
    load   = op inside {`EXE_LB, `EXE_LH, `EXE_LW, `EXE_LBU, `EXE_LHU};
    store  = op inside {`EXE_SB, `EXE_SH, `EXE_SW};
    br     = (op inside {`EXE_BEQ, `EXE_BNE, `EXE_BLEZ, `EXE_BGTZ}) ||
             (op == `EXE_REGIMM_INST && (rt inside {`EXE_BLTZ, `EXE_BGEZ}));
    br_lnk = (op == `EXE_REGIMM_INST) && (rt inside {`EXE_BLTZAL, `EXE_BGEZAL});
    jmp    = (op == `EXE_J);
    jal    = (op == `EXE_JAL);
    mfc0   = (op == `EXE_COP0_INST) && (rs == `EXE_MFC0);
    legal  = alu_r | muldiv | mfhi | mflo | mthi | mtlo | jr | jalr | quiet |
             imm | load | store | br | br_lnk | jmp | jal | mfc0;
    c          = '0;
    c.regwrite = alu_r | mfhi | mflo | jalr | imm | load | br_lnk | jal | mfc0;
    c.regdst   = (imm | load | mfc0) ? `REGDST_RT : (br_lnk | jal) ? `REGDST_RA : `REGDST_RD;
    c.alusrc   = imm | load | store;
    c.branch   = br | br_lnk;
    c.memwrite = store;
    c.memtoreg = load ? `RES_MEM : mfhi ? `RES_HI : mflo ? `RES_LO : `RES_ALU;
    c.hi_write = muldiv | mthi;
    c.lo_write = muldiv | mtlo;
    c.jump     = jmp | jal;
    c.jump_reg = jr | jalr;
    c.link     = br_lnk | jal;
    return legal ? c : CTRL_RESERVED;
endfunction

`endif

/* test/tb_decode_cluster.sv */
`timescale 1ns/1ns
`include "mips_macros.svh"

module tb_decode_cluster;
    import decode_pkg::*;
    `include "decode_model.svh"

    localparam int N_RANDOM = 200;
    localparam int WITHHOLD = 120;          // cycles with no downstream credit

    logic     clk = 1'b0;
    logic     reset;
    logic     in_valid;
    instr_t   in_instr;
    logic     out_credit;
    logic     in_credit;
    logic     out_valid;
    dec_pkt_t out_pkt;

    instr_t stim_q [$];                     // words not yet sent
    instr_t sent_q [$];                     // scoreboard in send order
    instr_t exp_head;
    logic   have_head     = 1'b0;
    logic   accepted_any  = 1'b0;
    logic   withheld_done = 1'b0;
    ctrl_t  exp_ctrl;
    int     up_credits    = `IN_DEPTH;      // sender side credits
    int     ds_count      = `OUT_CREDITS;   // returned minus received
    int     owed          = 0;              // credits downstream still has to give back
    int     hold_left     = 0;
    int     sent          = 0;
    int     received      = 0;
    int     credit_pulses = 0;
    int     errors        = 0;
    int     n_total       = 0;
    integer seed          = 79954;

    decode_cluster u_dut (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_pkt    (out_pkt)
    );

    always #2 clk = ~clk;

    assign exp_ctrl = model_decode(exp_head);   // decode of the oldest word sent

    task automatic flag_error(input string msg);
        errors++;
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    assert property (@(posedge clk) disable iff (reset) out_valid |-> have_head)
        else flag_error("packet out with nothing outstanding");
    assert property (@(posedge clk) disable iff (reset) out_valid |-> out_pkt.instr == exp_head)
        else flag_error($sformatf("instr %h, expected %h", $sampled(out_pkt.instr),
                                  $sampled(exp_head)));
    assert property (@(posedge clk) disable iff (reset) out_valid |-> out_pkt.ctrl == exp_ctrl)
        else flag_error($sformatf("ctrl %h for %h, expected %h", $sampled(out_pkt.ctrl),
                                  $sampled(exp_head), $sampled(exp_ctrl)));
    assert property (@(posedge clk) disable iff (reset)
                     out_valid && out_pkt.ctrl.invalid |-> out_pkt.ctrl == CTRL_RESERVED)
        else flag_error($sformatf("reserved %h has fields set", $sampled(out_pkt.instr)));
    assert property (@(posedge clk) disable iff (reset) out_valid |-> ds_count > 0)
        else flag_error("out_valid with no downstream credit");
    assert property (@(posedge clk) disable iff (reset) up_credits >= 0 && up_credits <= `IN_DEPTH)
        else flag_error($sformatf("upstream credits at %0d", $sampled(up_credits)));
    assert property (@(posedge clk) disable iff (reset) !accepted_any |-> !out_valid && !in_credit)
        else flag_error("output activity before first accept");

    //////////////////////////////////////////////////
    // upstream sender and downstream sink
    //////////////////////////////////////////////////
    always @(posedge clk) begin : drive
        instr_t w;
        if (!reset) begin
            if (in_credit) begin                // one entry freed
                up_credits++;
                credit_pulses++;
            end
            if (in_valid) begin
                accepted_any = 1'b1;
            end
            if (out_credit) begin
                ds_count++;
            end
            if (out_valid) begin
                ds_count--;
                received++;
                owed++;
                if (sent_q.size() != 0) begin
                    w = sent_q.pop_front();
                end
            end
            // next word after a random gap
            if (stim_q.size() != 0 && up_credits > 0 && ($random(seed) & 3) != 0) begin
                w = stim_q.pop_front();
                in_valid <= 1'b1;
                in_instr <= w;
                sent_q.push_back(w);
                up_credits--;
                sent++;
            end else begin
                in_valid <= 1'b0;
            end
            if (received >= 60 && !withheld_done) begin
                hold_left     = WITHHOLD;       // one long stall downstream
                withheld_done = 1'b1;
            end
            if (hold_left > 0) begin
                hold_left--;
                out_credit <= 1'b0;
            end else if (owed > 0 && ($random(seed) & 1)) begin
                owed--;
                out_credit <= 1'b1;
            end else begin
                out_credit <= 1'b0;
            end
            have_head = (sent_q.size() != 0);
            if (have_head) begin
                exp_head = sent_q[0];
            end
        end
    end

    initial begin
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_instr   = '0;
        out_credit = 1'b0;
        for (int k = 0; k < 64; k++) begin
            stim_q.push_back({6'(k), 5'd1, 5'd2, 16'h8000});                // every opcode
        end
        for (int k = 0; k < 64; k++) begin
            stim_q.push_back({`EXE_NOP, 5'd3, 5'd4, 5'd5, 5'd0, 6'(k)});    // every funct
        end
        for (int k = 0; k < 32; k++) begin
            stim_q.push_back({`EXE_REGIMM_INST, 5'd6, 5'(k), 16'hfffc});    // every regimm rt
            stim_q.push_back({`EXE_COP0_INST, 5'(k), 5'd7, 5'd12, 11'd0});  // every cop0 rs
        end
        for (int k = 0; k < N_RANDOM; k++) begin
            stim_q.push_back($random(seed));
        end
        n_total = stim_q.size();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        wait (received == n_total);
        repeat (4) @(posedge clk);              // let the last credits settle
        assert (sent == n_total && sent_q.size() == 0)
            else flag_error($sformatf("%0d sent, %0d still outstanding", sent, sent_q.size()));
        assert (credit_pulses == sent)
            else flag_error($sformatf("%0d in_credit pulses for %0d words", credit_pulses, sent));
        assert (up_credits == `IN_DEPTH)
            else flag_error($sformatf("upstream credits end at %0d", up_credits));
        $display("closing: %0d errors, %0d sent, %0d received", errors, sent, received);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog allows 20 cycles per word plus the stall and reset
    initial begin
        wait (n_total > 0);
        #((n_total * 20 + WITHHOLD + 8) * 4);
        $display("timeout: only %0d of %0d instructions came out", received, n_total);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* verilog/decode_cluster.sv */
`timescale 1ns/1ns
`include "mips_macros.svh"

module decode_cluster (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  decode_pkg::instr_t   in_instr,
    input  logic                 out_credit,
    output logic                 in_credit,
    output logic                 out_valid,
    output decode_pkg::dec_pkt_t out_pkt
);
    import decode_pkg::*;

    lane_mask_t lane_load;
    lane_mask_t lane_free;
    lane_mask_t lane_valid;
    lane_mask_t lane_take;
    instr_t     lane_instr;                 // shared head word, one lane loads it
    dec_pkt_t   lane_pkt [`NUM_LANES];

    issue_dispatch u_dispatch (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .lane_free  (lane_free),
        .in_credit  (in_credit),
        .lane_load  (lane_load),
        .lane_instr (lane_instr)
    );

    //////////////////////////////////////////////////
    // decode lanes
    //////////////////////////////////////////////////
    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        decode_lane u_lane (
            .clk   (clk),
            .reset (reset),
            .load  (lane_load[i]),
            .instr (lane_instr),
            .take  (lane_take[i]),
            .valid (lane_valid[i]),
            .pkt   (lane_pkt[i]),
            .free  (lane_free[i])
        );
    end

    retire_collector u_collect (
        .clk        (clk),
        .reset      (reset),
        .lane_valid (lane_valid),
        .lane_pkt   (lane_pkt),
        .out_credit (out_credit),
        .lane_take  (lane_take),
        .out_valid  (out_valid),
        .out_pkt    (out_pkt)
    );

endmodule

/* verilog/decode_lane.sv */
`timescale 1ns/1ns

module decode_lane (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  decode_pkg::instr_t   instr,
    input  logic                 take,
    output logic                 valid,
    output decode_pkg::dec_pkt_t pkt,
    output logic                 free
);
    import decode_pkg::*;

    ctrl_t dec_ctrl;        // combinational decode of the incoming word

    main_decoder u_dec (
        .instr (instr),
        .ctrl  (dec_ctrl)
    );

    //////////////////////////////////////////////////
    // slot state
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
            free  <= 1'b0;
        end else begin
            free <= take;                   // credit back to dispatch next cycle
            if (load) begin
                valid <= 1'b1;
            end else if (take) begin
                valid <= 1'b0;
            end
        end
    end

    // packet register, written only on load
    always_ff @(posedge clk) begin
        if (load) begin
            pkt.instr <= instr;
            pkt.ctrl  <= dec_ctrl;
        end
    end

endmodule

/* verilog/decode_pkg.sv */
`include "mips_macros.svh"

package decode_pkg;

    typedef logic [31:0] instr_t;                                 // raw instruction word
    typedef logic [$clog2(`NUM_LANES)-1:0] lane_idx_t;           // rotation pointer
    typedef logic [`NUM_LANES-1:0] lane_mask_t;                   // one bit per lane
    typedef logic [$clog2(`IN_DEPTH)-1:0] buf_ptr_t;             // dispatch buffer index
    typedef logic [$clog2(`IN_DEPTH+1)-1:0] buf_cnt_t;           // 0..IN_DEPTH
    typedef logic [$clog2(`OUT_CREDITS+1)-1:0] credit_cnt_t;     // 0..OUT_CREDITS
    typedef logic [1:0] regdst_t;                                 // rd / rt / ra
    typedef logic [1:0] res_src_t;                                // alu / mem / hi / lo

    // main decoder output, 14 bits
    typedef struct packed {
        logic     regwrite;
        regdst_t  regdst;
        logic     alusrc;       // 1 -> immediate operand
        logic     branch;
        logic     memwrite;
        res_src_t memtoreg;
        logic     hi_write;
        logic     lo_write;
        logic     jump;         // j / jal target
        logic     jump_reg;     // jr / jalr
        logic     link;
        logic     invalid;      // reserved instruction
    } ctrl_t;

    // word plus its control, 46 bits
    typedef struct packed {
        instr_t instr;
        ctrl_t  ctrl;
    } dec_pkt_t;

endpackage

/* verilog/issue_dispatch.sv */
`timescale 1ns/1ns
`include "mips_macros.svh"

module issue_dispatch (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  decode_pkg::instr_t     in_instr,
    input  decode_pkg::lane_mask_t lane_free,
    output logic                   in_credit,
    output decode_pkg::lane_mask_t lane_load,
    output decode_pkg::instr_t     lane_instr
);
    import decode_pkg::*;

    instr_t     buf_mem [`IN_DEPTH];    // circular buffer
    buf_ptr_t   wr_ptr;
    buf_ptr_t   rd_ptr;
    buf_cnt_t   count;                  // occupied entries
    lane_mask_t lane_cred;              // one credit per lane
    lane_idx_t  lane_ptr;               // next lane in rotation
    logic       issue;

    // head goes out when the pointed lane is free
    assign issue      = (count != '0) && lane_cred[lane_ptr];
    assign lane_instr = buf_mem[rd_ptr];

    always_comb begin
        lane_load = '0;
        if (issue) begin
            lane_load[lane_ptr] = 1'b1;     // one-hot load
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            buf_mem[wr_ptr] <= in_instr;    // sender only sends with a credit
        end
    end

    //////////////////////////////////////////////////
    // pointers, occupancy, credits
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            lane_cred <= '1;                // every lane empty
            lane_ptr  <= '0;
            in_credit <= 1'b0;
        end else begin
            in_credit <= issue;             // entry freed -> credit upstream
            if (in_valid) begin
                wr_ptr <= (wr_ptr == buf_ptr_t'(`IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (issue) begin
                rd_ptr   <= (rd_ptr == buf_ptr_t'(`IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                lane_ptr <= (lane_ptr == lane_idx_t'(`NUM_LANES - 1)) ? '0 : lane_ptr + 1'b1;
            end
            count     <= count + buf_cnt_t'(in_valid) - buf_cnt_t'(issue);
            lane_cred <= (lane_cred & ~lane_load) | lane_free;  // spend on load, refill on free
        end
    end

endmodule

/* verilog/main_decoder.sv */
`timescale 1ns/1ns
`include "mips_macros.svh"

module main_decoder (
    input  decode_pkg::instr_t instr,
    output decode_pkg::ctrl_t  ctrl
);

    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [5:0] funct;

    // instruction fields
    assign op    = instr[31:26];
    assign rs    = instr[25:21];
    assign rt    = instr[20:16];
    assign funct = instr[5:0];

    always_comb begin
        ctrl = '0;                                      // everything off by default
        case (op)
            //////////////////////////////////////////////////
            // special group, split on funct
            //////////////////////////////////////////////////
            `EXE_NOP: begin
                case (funct)
                    `EXE_AND, `EXE_OR, `EXE_XOR, `EXE_NOR,
                    `EXE_SLL, `EXE_SRL, `EXE_SRA, `EXE_SLLV, `EXE_SRLV, `EXE_SRAV,
                    `EXE_ADD, `EXE_ADDU, `EXE_SUB, `EXE_SUBU, `EXE_SLT, `EXE_SLTU: begin
                        ctrl.regwrite = 1'b1;           // rd <- alu
                        ctrl.regdst   = `REGDST_RD;
                        ctrl.memtoreg = `RES_ALU;
                    end
                    `EXE_MULT, `EXE_MULTU, `EXE_DIV, `EXE_DIVU: begin
                        ctrl.hi_write = 1'b1;           // result pair into hi/lo
                        ctrl.lo_write = 1'b1;
                    end
                    `EXE_MFHI: begin
                        ctrl.regwrite = 1'b1;
                        ctrl.regdst   = `REGDST_RD;
                        ctrl.memtoreg = `RES_HI;        // hi -> gpr
                    end
                    `EXE_MFLO: begin
                        ctrl.regwrite = 1'b1;
                        ctrl.regdst   = `REGDST_RD;
                        ctrl.memtoreg = `RES_LO;        // lo -> gpr
                    end
                    `EXE_MTHI: ctrl.hi_write = 1'b1;    // gpr -> hi
                    `EXE_MTLO: ctrl.lo_write = 1'b1;    // gpr -> lo
                    `EXE_JR:   ctrl.jump_reg = 1'b1;
                    `EXE_JALR: begin
                        ctrl.jump_reg = 1'b1;
                        ctrl.regwrite = 1'b1;           // return addr into rd
                        ctrl.regdst   = `REGDST_RD;
                    end
                    `EXE_SYSCALL, `EXE_BREAK: ctrl = '0; // legal, trap handled later
                    default:   ctrl.invalid = 1'b1;
                endcase
            end

            // immediate alu, rt destination
            `EXE_ANDI, `EXE_ORI, `EXE_XORI, `EXE_LUI,
            `EXE_ADDI, `EXE_ADDIU, `EXE_SLTI, `EXE_SLTIU: begin
                ctrl.regwrite = 1'b1;
                ctrl.regdst   = `REGDST_RT;
                ctrl.alusrc   = 1'b1;
            end

            `EXE_BEQ, `EXE_BNE, `EXE_BLEZ, `EXE_BGTZ: ctrl.branch = 1'b1;

            `EXE_REGIMM_INST: begin
                case (rt)
                    `EXE_BLTZ, `EXE_BGEZ: ctrl.branch = 1'b1;
                    `EXE_BLTZAL, `EXE_BGEZAL: begin
                        ctrl.branch   = 1'b1;
                        ctrl.regwrite = 1'b1;           // $ra <- pc + 8
                        ctrl.regdst   = `REGDST_RA;
                        ctrl.link     = 1'b1;
                    end
                    default: ctrl.invalid = 1'b1;
                endcase
            end

            `EXE_J:   ctrl.jump = 1'b1;
            `EXE_JAL: begin
                ctrl.jump     = 1'b1;
                ctrl.regwrite = 1'b1;
                ctrl.regdst   = `REGDST_RA;
                ctrl.link     = 1'b1;
            end

            //////////////////////////////////////////////////
            // memory
            //////////////////////////////////////////////////
            `EXE_LB, `EXE_LBU, `EXE_LH, `EXE_LHU, `EXE_LW: begin
                ctrl.regwrite = 1'b1;
                ctrl.regdst   = `REGDST_RT;
                ctrl.alusrc   = 1'b1;                   // base + offset
                ctrl.memtoreg = `RES_MEM;
            end
            `EXE_SB, `EXE_SH, `EXE_SW: begin
                ctrl.alusrc   = 1'b1;
                ctrl.memwrite = 1'b1;
            end

            // privileged, cp0 side effects are out of this block
            `EXE_COP0_INST: begin
                case (rs)
                    `EXE_MFC0: begin
                        ctrl.regwrite = 1'b1;           // cp0 -> rt
                        ctrl.regdst   = `REGDST_RT;
                    end
                    `EXE_MTC0, `EXE_ERET: ctrl = '0;    // no gpr write
                    default: ctrl.invalid = 1'b1;
                endcase
            end

            default: ctrl.invalid = 1'b1;               // unknown opcode
        endcase
    end

endmodule

/* verilog/mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

//////////////////////////////////////////////////
// cluster sizing
//////////////////////////////////////////////////
`define NUM_LANES       4           // decode lanes, power of two
`define IN_DEPTH        4           // dispatch buffer entries = upstream credits
`define OUT_CREDITS     2           // credits toward downstream after reset

// destination register select
`define REGDST_RD       2'b00
`define REGDST_RT       2'b01
`define REGDST_RA       2'b10       // $31 for link forms

// result source
`define RES_ALU         2'b00
`define RES_MEM         2'b01
`define RES_HI          2'b10
`define RES_LO          2'b11

//////////////////////////////////////////////////
// opcodes
//////////////////////////////////////////////////
`define EXE_NOP         6'b000000   // special, decode by funct
`define EXE_REGIMM_INST 6'b000001   // decode by rt
`define EXE_J           6'b000010
`define EXE_JAL         6'b000011
`define EXE_BEQ         6'b000100
`define EXE_BNE         6'b000101
`define EXE_BLEZ        6'b000110
`define EXE_BGTZ        6'b000111
`define EXE_ADDI        6'b001000
`define EXE_ADDIU       6'b001001
`define EXE_SLTI        6'b001010
`define EXE_SLTIU       6'b001011
`define EXE_ANDI        6'b001100
`define EXE_ORI         6'b001101
`define EXE_XORI        6'b001110
`define EXE_LUI         6'b001111
`define EXE_COP0_INST   6'b010000   // decode by rs
`define EXE_LB          6'b100000
`define EXE_LH          6'b100001
`define EXE_LW          6'b100011
`define EXE_LBU         6'b100100
`define EXE_LHU         6'b100101
`define EXE_SB          6'b101000
`define EXE_SH          6'b101001
`define EXE_SW          6'b101011

// funct codes under EXE_NOP
`define EXE_SLL         6'b000000
`define EXE_SRL         6'b000010
`define EXE_SRA         6'b000011
`define EXE_SLLV        6'b000100
`define EXE_SRLV        6'b000110
`define EXE_SRAV        6'b000111
`define EXE_JR          6'b001000
`define EXE_JALR        6'b001001
`define EXE_SYSCALL     6'b001100
`define EXE_BREAK       6'b001101
`define EXE_MFHI        6'b010000
`define EXE_MTHI        6'b010001
`define EXE_MFLO        6'b010010
`define EXE_MTLO        6'b010011
`define EXE_MULT        6'b011000
`define EXE_MULTU       6'b011001
`define EXE_DIV         6'b011010
`define EXE_DIVU        6'b011011
`define EXE_ADD         6'b100000
`define EXE_ADDU        6'b100001
`define EXE_SUB         6'b100010
`define EXE_SUBU        6'b100011
`define EXE_AND         6'b100100
`define EXE_OR          6'b100101
`define EXE_XOR         6'b100110
`define EXE_NOR         6'b100111
`define EXE_SLT         6'b101010
`define EXE_SLTU        6'b101011

// rt codes under REGIMM
`define EXE_BLTZ        5'b00000
`define EXE_BGEZ        5'b00001
`define EXE_BLTZAL      5'b10000
`define EXE_BGEZAL      5'b10001

// rs codes under COP0
`define EXE_MFC0        5'b00000
`define EXE_MTC0        5'b00100
`define EXE_ERET        5'b10000

`endif

/* verilog/retire_collector.sv */
`timescale 1ns/1ns
`include "mips_macros.svh"

module retire_collector (
    input  logic                   clk,
    input  logic                   reset,
    input  decode_pkg::lane_mask_t lane_valid,
    input  decode_pkg::dec_pkt_t   lane_pkt [`NUM_LANES],
    input  logic                   out_credit,
    output decode_pkg::lane_mask_t lane_take,
    output logic                   out_valid,
    output decode_pkg::dec_pkt_t   out_pkt
);
    import decode_pkg::*;

    lane_idx_t   take_ptr;      // same rotation as dispatch
    credit_cnt_t credits;       // downstream slots left
    logic        send;

    // only the pointed lane may drain, keeps program order
    assign send = lane_valid[take_ptr] && (credits != '0);

    always_comb begin
        lane_take = '0;
        if (send) begin
            lane_take[take_ptr] = 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // pointer and credit counter
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            take_ptr  <= '0;
            credits   <= credit_cnt_t'(`OUT_CREDITS);
            out_valid <= 1'b0;
        end else begin
            out_valid <= send;
            if (send) begin
                take_ptr <= (take_ptr == lane_idx_t'(`NUM_LANES - 1)) ? '0 : take_ptr + 1'b1;
            end
            case ({send, out_credit})
                2'b10:   credits <= credits - 1'b1;     // spent one
                2'b01:   credits <= credits + 1'b1;     // one returned
                default: credits <= credits;            // none, or both cancel
            endcase
        end
    end

    // output payload, held between sends
    always_ff @(posedge clk) begin
        if (send) begin
            out_pkt <= lane_pkt[take_ptr];
        end
    end

endmodule
